// File: src/eeprom_pkg.sv
`default_nettype none

// device level view of the 24C16 style part
package eeprom_pkg;

    localparam int ADDR_W = 11;                  // 2 Kbyte array

    // fixed upper nibble of every control byte
    localparam logic [3:0] DEV_TYPE = 4'b1010;

    // which byte the shifter is loaded with
    typedef enum logic [1:0] {
        BYTE_CTRL_WR = 2'd0,                     // control byte, r/w = 0
        BYTE_CTRL_RD = 2'd1,                     // control byte, r/w = 1
        BYTE_ADDR    = 2'd2,                     // low 8 address bits
        BYTE_DATA    = 2'd3
    } byte_sel_e;

endpackage

`default_nettype wire

// File: src/twi_pkg.sv
`default_nettype none

package twi_pkg;

    // commands understood by the bit engine
    typedef enum logic [1:0] {
        CMD_START = 2'd0,                        // also used for repeated start
        CMD_STOP  = 2'd1,
        CMD_WRITE = 2'd2,
        CMD_READ  = 2'd3
    } bit_cmd_e;

    typedef enum logic [3:0] {
        IDLE     = 4'd0,
        START    = 4'd1,
        SEND     = 4'd2,
        GET_ACK  = 4'd3,
        RESTART  = 4'd4,
        RECV     = 4'd5,
        PUT_NACK = 4'd6,
        STOP     = 4'd7,
        FINISH   = 4'd8
    } ctrl_state_e;

    // quarters of one scl period
    typedef enum logic [1:0] {PH0, PH1, PH2, PH3} phase_e;

endpackage

`default_nettype wire

// File: src/byte_shifter.sv
`timescale 1ns/100ps
`default_nettype none

module byte_shifter (
    input  logic       CLK,
    input  logic       RESET,
    input  logic       load,
    input  logic       shift,
    input  logic [7:0] din,
    input  logic       rx_bit,
    output logic       tx_msb,
    output logic       byte_end,
    output logic [7:0] dout
);

    logic [7:0] sreg;
    logic [3:0] bit_cnt;

    // msb first on the wire, received bits enter at the bottom
    always_ff @(posedge CLK)
    begin
        if (load)
        begin
            sreg <= din;
        end
        else if (shift)
        begin
            sreg <= {sreg[6:0], rx_bit};
        end
    end

    always_ff @(posedge CLK)
    begin
        if (RESET)
        begin
            bit_cnt <= 4'd0;
        end
        else if (load)
        begin
            bit_cnt <= 4'd0;
        end
        else if (shift && !byte_end)
        begin
            bit_cnt <= bit_cnt + 4'd1;              // stops at 8
        end
    end

    assign tx_msb   = sreg[7];
    assign byte_end = (bit_cnt == 4'd8);
    assign dout     = sreg;

endmodule

`default_nettype wire

// File: src/request_latch.sv
`timescale 1ns/100ps
`default_nettype none

module request_latch (
    input  logic                          CLK,
    input  logic                          RESET,
    input  logic                          capture,
    input  logic                          is_read,
    input  logic [eeprom_pkg::ADDR_W-1:0] addr,
    input  logic [7:0]                    wdata,
    input  eeprom_pkg::byte_sel_e         sel,
    input  logic                          store,
    input  logic [7:0]                    rx_byte,
    input  logic                          set_err,
    output logic [7:0]                    tx_byte,
    output logic [7:0]                    rd_data,
    output logic                          nack_err
);
    import eeprom_pkg::*;

    logic [ADDR_W-1:0] addr_q;
    logic [7:0]        wdata_q;
    logic [2:0]        block;

    always_ff @(posedge CLK)
    begin
        if (capture)
        begin
            addr_q <= addr;
        end
        if (capture && !is_read)
        begin
            wdata_q <= wdata;                       // a read leaves the last write data alone
        end
    end

    always_ff @(posedge CLK)
    begin
        if (RESET)
        begin
            rd_data  <= 8'h00;
            nack_err <= 1'b0;
        end
        else
        begin
            if (store)
            begin
                rd_data <= rx_byte;
            end
            if (capture)
            begin
                nack_err <= 1'b0;
            end
            else if (set_err)
            begin
                nack_err <= 1'b1;
            end
        end
    end

    assign block = addr_q[ADDR_W-1 -: 3];           // a10..a8 ride in the control byte

    always_comb
    begin
        case (sel)
            BYTE_CTRL_WR: tx_byte = {DEV_TYPE, block, 1'b0};
            BYTE_CTRL_RD: tx_byte = {DEV_TYPE, block, 1'b1};
            BYTE_ADDR:    tx_byte = addr_q[7:0];
            default:      tx_byte = wdata_q;
        endcase
    end

endmodule

`default_nettype wire

// File: src/twi_bit_engine.sv
`timescale 1ns/100ps
`default_nettype none

module twi_bit_engine #(
    parameter int CLK_DIV = 4                       // CLK cycles per quarter bit
) (
    input  logic              CLK,
    input  logic              RESET,
    input  logic              cmd_valid,
    input  twi_pkg::bit_cmd_e cmd,
    input  logic              tx_bit,
    output logic              cmd_done,
    output logic              rx_bit,
    output logic              scl,
    output logic              sda_oe,
    input  logic              sda_in
);
    import twi_pkg::*;

    localparam int DIV_W = (CLK_DIV > 1) ? $clog2(CLK_DIV) : 1;

    logic [DIV_W-1:0] div_cnt;
    phase_e           phase;
    phase_e           ph_next;
    logic             active;
    bit_cmd_e         cmd_q;
    logic             tx_q;
    logic             quarter_end;

    // bus levels {scl, sda_oe} for one quarter of a command
    function automatic logic [1:0] bus_level(
        input bit_cmd_e c,
        input phase_e   ph,
        input logic     b,
        input logic     scl_now
    );
        logic [1:0] lvl;
        case (c)
            CMD_START:
                case (ph)
                    PH0:     lvl = {scl_now, 1'b0}; // release sda, scl stays put
                    PH1:     lvl = 2'b10;
                    PH2:     lvl = 2'b11;           // sda falls with scl high
                    default: lvl = 2'b01;
                endcase
            CMD_STOP:
                case (ph)
                    PH0:     lvl = 2'b01;
                    PH1:     lvl = 2'b11;
                    default: lvl = 2'b10;           // sda rises with scl high
                endcase
            CMD_WRITE:
                lvl = {(ph == PH1) || (ph == PH2), !b};
            default:
                lvl = {(ph == PH1) || (ph == PH2), 1'b0};
        endcase
        return lvl;
    endfunction

    assign quarter_end = active && (div_cnt == DIV_W'(CLK_DIV - 1));
    assign ph_next     = phase_e'(phase + 2'd1);

    always_ff @(posedge CLK)
    begin
        if (RESET)
        begin
            active   <= 1'b0;
            phase    <= PH0;
            div_cnt  <= '0;
            cmd_done <= 1'b0;
            rx_bit   <= 1'b0;
            scl      <= 1'b1;
            sda_oe   <= 1'b0;
        end
        else
        begin
            cmd_done <= 1'b0;
            if (!active)
            begin
                if (cmd_valid)
                begin
                    active  <= 1'b1;
                    phase   <= PH0;
                    div_cnt <= '0;
                    cmd_q   <= cmd;
                    tx_q    <= tx_bit;
                    {scl, sda_oe} <= bus_level(cmd, PH0, tx_bit, scl);
                end
            end
            else if (quarter_end)
            begin
                div_cnt <= '0;
                if (phase == PH1)
                begin
                    rx_bit <= sda_in;               // middle of scl high
                end
                if (phase == PH3)
                begin
                    active   <= 1'b0;
                    cmd_done <= 1'b1;
                end
                else
                begin
                    phase <= ph_next;
                    {scl, sda_oe} <= bus_level(cmd_q, ph_next, tx_q, scl);
                end
            end
            else
            begin
                div_cnt <= div_cnt + 1'b1;
            end
        end
    end

endmodule

`default_nettype wire

// File: src/eeprom_ctrl.sv
`timescale 1ns/100ps
`default_nettype none

module eeprom_ctrl (
    input  logic                  CLK,
    input  logic                  RESET,
    input  logic                  wr,
    input  logic                  rd,
    input  logic                  cmd_done,
    input  logic                  rx_bit,
    input  logic                  tx_msb,
    input  logic                  byte_end,
    output logic                  busy,
    output logic                  done,
    output logic                  cmd_valid,
    output twi_pkg::bit_cmd_e     cmd,
    output logic                  tx_bit,
    output logic                  load,
    output logic                  shift,
    output eeprom_pkg::byte_sel_e sel,
    output logic                  capture,
    output logic                  is_read,
    output logic                  store,
    output logic                  set_err
);
    import twi_pkg::*;
    import eeprom_pkg::*;

    ctrl_state_e state;
    logic        rd_op;                             // transfer is a random read
    logic        shifted;                           // byte_end valid after a shift

    assign capture = (state == IDLE) && (wr || rd);
    assign is_read = rd && !wr;                     // wr wins
    assign shift   = cmd_done && ((state == SEND) || (state == RECV));
    assign tx_bit  = (state == PUT_NACK) ? 1'b1 : tx_msb;

    always_comb
    begin
        case (state)
            START, RESTART: cmd = CMD_START;
            SEND, PUT_NACK: cmd = CMD_WRITE;
            GET_ACK, RECV:  cmd = CMD_READ;
            default:        cmd = CMD_STOP;
        endcase
    end

    always_ff @(posedge CLK)
    begin
        if (RESET)
        begin
            state     <= IDLE;
            busy      <= 1'b0;
            done      <= 1'b0;
            cmd_valid <= 1'b0;
            load      <= 1'b0;
            store     <= 1'b0;
            set_err   <= 1'b0;
            sel       <= BYTE_CTRL_WR;
            rd_op     <= 1'b0;
            shifted   <= 1'b0;
        end
        else
        begin
            cmd_valid <= 1'b0;
            load      <= 1'b0;
            store     <= 1'b0;
            set_err   <= 1'b0;
            done      <= 1'b0;
            shifted   <= shift;
            case (state)
                IDLE:
                    if (capture)
                    begin
                        busy      <= 1'b1;
                        rd_op     <= is_read;
                        cmd_valid <= 1'b1;
                        state     <= START;
                    end
                START, RESTART:
                    if (cmd_done)
                    begin
                        sel   <= (state == START) ? BYTE_CTRL_WR : BYTE_CTRL_RD;
                        load  <= 1'b1;
                        state <= SEND;
                    end
                SEND, RECV:
                    // first bit right after load, next bits once the count settles
                    if (load || (shifted && !byte_end))
                    begin
                        cmd_valid <= 1'b1;
                    end
                    else if (shifted)
                    begin
                        cmd_valid <= 1'b1;
                        if (state == SEND)
                        begin
                            state <= GET_ACK;
                        end
                        else
                        begin
                            store <= 1'b1;
                            state <= PUT_NACK;
                        end
                    end
                GET_ACK:
                    if (cmd_done)
                    begin
                        if (rx_bit)
                        begin
                            set_err   <= 1'b1;  // no ack, abort with a stop
                            cmd_valid <= 1'b1;
                            state     <= STOP;
                        end
                        else
                        begin
                            case (sel)
                                BYTE_CTRL_WR:
                                begin
                                    sel   <= BYTE_ADDR;
                                    load  <= 1'b1;
                                    state <= SEND;
                                end
                                BYTE_ADDR:
                                    if (rd_op)
                                    begin
                                        cmd_valid <= 1'b1;
                                        state     <= RESTART;
                                    end
                                    else
                                    begin
                                        sel   <= BYTE_DATA;
                                        load  <= 1'b1;
                                        state <= SEND;
                                    end
                                BYTE_CTRL_RD:
                                begin
                                    load  <= 1'b1;  // clears the bit count
                                    state <= RECV;
                                end
                                default:
                                begin
                                    cmd_valid <= 1'b1;
                                    state     <= STOP;
                                end
                            endcase
                        end
                    end
                PUT_NACK:
                    if (cmd_done)
                    begin
                        cmd_valid <= 1'b1;
                        state     <= STOP;
                    end
                STOP:
                    if (cmd_done)
                    begin
                        state <= FINISH;
                    end
                FINISH:
                begin
                    busy  <= 1'b0;
                    done  <= 1'b1;
                    state <= IDLE;
                end
                default:
                    state <= IDLE;
            endcase
        end
    end

endmodule

`default_nettype wire

// File: src/eeprom_master_top.sv
`timescale 1ns/100ps
`default_nettype none

module eeprom_master_top #(
    parameter int CLK_DIV = 4
) (
    input  logic                          CLK,
    input  logic                          RESET,
    input  logic                          wr,
    input  logic                          rd,
    input  logic [eeprom_pkg::ADDR_W-1:0] addr,
    input  logic [7:0]                    wdata,
    output logic                          busy,
    output logic                          done,
    output logic                          nack_err,
    output logic [7:0]                    rd_data,
    output logic                          scl,
    output logic                          sda_oe,
    input  logic                          sda_in
);
    import twi_pkg::*;
    import eeprom_pkg::*;

    logic      cmd_valid;
    bit_cmd_e  cmd;
    logic      tx_bit;
    logic      cmd_done;
    logic      rx_bit;
    logic      load;
    logic      shift;
    logic      tx_msb;
    logic      byte_end;
    logic [7:0] shift_byte;
    logic [7:0] tx_byte;
    byte_sel_e sel;
    logic      capture;
    logic      is_read;
    logic      store;
    logic      set_err;

    eeprom_ctrl u_ctrl (
        .CLK       (CLK),
        .RESET     (RESET),
        .wr        (wr),
        .rd        (rd),
        .cmd_done  (cmd_done),
        .rx_bit    (rx_bit),
        .tx_msb    (tx_msb),
        .byte_end  (byte_end),
        .busy      (busy),
        .done      (done),
        .cmd_valid (cmd_valid),
        .cmd       (cmd),
        .tx_bit    (tx_bit),
        .load      (load),
        .shift     (shift),
        .sel       (sel),
        .capture   (capture),
        .is_read   (is_read),
        .store     (store),
        .set_err   (set_err)
    );

    twi_bit_engine #(
        .CLK_DIV (CLK_DIV)
    ) u_bit (
        .CLK       (CLK),
        .RESET     (RESET),
        .cmd_valid (cmd_valid),
        .cmd       (cmd),
        .tx_bit    (tx_bit),
        .cmd_done  (cmd_done),
        .rx_bit    (rx_bit),
        .scl       (scl),
        .sda_oe    (sda_oe),
        .sda_in    (sda_in)
    );

    byte_shifter u_shift (
        .CLK      (CLK),
        .RESET    (RESET),
        .load     (load),
        .shift    (shift),
        .din      (tx_byte),
        .rx_bit   (rx_bit),
        .tx_msb   (tx_msb),
        .byte_end (byte_end),
        .dout     (shift_byte)
    );

    request_latch u_req (
        .CLK      (CLK),
        .RESET    (RESET),
        .capture  (capture),
        .is_read  (is_read),
        .addr     (addr),
        .wdata    (wdata),
        .sel      (sel),
        .store    (store),
        .rx_byte  (shift_byte),
        .set_err  (set_err),
        .tx_byte  (tx_byte),
        .rd_data  (rd_data),
        .nack_err (nack_err)
    );

endmodule

`default_nettype wire

// File: tb/eeprom_model.sv
`timescale 1ns/100ps
`default_nettype none

module eeprom_model (
    input  wire logic scl,
    input  wire logic sda,
    output logic      pull
);
    localparam int M_IDLE   = 0;
    localparam int M_CTRL   = 1;
    localparam int M_ADDR   = 2;
    localparam int M_DATA   = 3;
    localparam int M_TX     = 4;
    localparam int M_IGNORE = 5;

    logic [7:0] mem [0:2047];
    logic [7:0] sh;
    logic [7:0] tx_byte;
    logic [7:0] lo;
    logic [2:0] blk;
    logic       ack_drive;
    logic       ack;
    logic       scl_q;
    logic       sda_q;
    int         mode;
    int         bit_cnt;
    int         tx_cnt;

    initial
    begin
        for (int i = 0; i < 2048; i++)
        begin
            mem[i] = 8'(i) ^ {3'(i >> 8), 5'h15};   // depends on all 11 bits
        end
        pull      = 1'b0;
        ack_drive = 1'b0;
        mode      = M_IDLE;
        bit_cnt   = 0;
        tx_cnt    = 0;
        lo        = 8'h00;
        blk       = 3'd0;
        scl_q     = 1'b1;
        sda_q     = 1'b1;
    end

    always @(scl or sda)
    begin
        ack = 1'b1;
        if (scl === 1'b1 && scl_q === 1'b1 && sda_q === 1'b1 && sda === 1'b0)
        begin
            mode      = M_CTRL;                     // start or repeated start
            bit_cnt   = 0;
            ack_drive = 1'b0;
            pull      = 1'b0;
        end
        else if (scl === 1'b1 && scl_q === 1'b1 && sda_q === 1'b0 && sda === 1'b1)
        begin
            mode      = M_IDLE;                     // stop
            ack_drive = 1'b0;
            pull      = 1'b0;
        end
        else if (scl === 1'b1 && scl_q === 1'b0)
        begin
            if ((mode == M_CTRL || mode == M_ADDR || mode == M_DATA) && bit_cnt < 8)
            begin
                sh      = {sh[6:0], sda};
                bit_cnt = bit_cnt + 1;
            end
        end
        else if (scl === 1'b0 && scl_q === 1'b1)
        begin
            if (ack_drive)
            begin
                ack_drive = 1'b0;
                bit_cnt   = 0;
                if (mode == M_TX)
                begin
                    pull   = !tx_byte[7];
                    tx_cnt = 1;
                end
                else
                begin
                    pull = 1'b0;
                end
            end
            else if (mode == M_TX)
            begin
                if (tx_cnt < 8)
                begin
                    pull   = !tx_byte[7 - tx_cnt];
                    tx_cnt = tx_cnt + 1;
                end
                else
                begin
                    pull = 1'b0;                    // master nacks here
                    mode = M_IGNORE;
                end
            end
            else if (bit_cnt == 8)
            begin
                case (mode)
                    M_CTRL:
                        if (sh[7:4] == 4'b1010 && sh[3:1] != 3'd7)
                        begin
                            blk = sh[3:1];
                            if (sh[0])
                            begin
                                tx_byte = mem[{blk, lo}];
                                mode    = M_TX;
                            end
                            else
                            begin
                                mode = M_ADDR;
                            end
                        end
                        else
                        begin
                            ack  = 1'b0;            // block 7 is absent
                            mode = M_IGNORE;
                        end
                    M_ADDR:
                    begin
                        lo   = sh;
                        mode = M_DATA;
                    end
                    M_DATA:
                    begin
                        mem[{blk, lo}] = sh;
                        mode = M_IGNORE;
                    end
                    default:
                        ack = 1'b0;
                endcase
                if (ack)
                begin
                    pull      = 1'b1;
                    ack_drive = 1'b1;
                end
            end
        end
        scl_q = scl;
        sda_q = sda;
    end

endmodule

`default_nettype wire

// File: tb/eeprom_properties.sv
`timescale 1ns/100ps
`default_nettype none

module eeprom_properties (
    input wire logic              CLK,
    input wire logic              RESET,
    input wire logic              busy,
    input wire logic              done,
    input wire logic              scl,
    input wire logic              sda_oe,
    input wire twi_pkg::bit_cmd_e cmd
);
    import twi_pkg::*;

    done_one_cycle: assert property (@(posedge CLK) disable iff (RESET)
        done |=> !done)
        else $error("done longer than one cycle");

    done_with_busy_fall: assert property (@(posedge CLK) disable iff (RESET)
        done |-> (!busy && $past(busy)))
        else $error("done without busy falling");

    released_after_reset: assert property (@(posedge CLK)
        ($past(RESET) && !RESET) |-> (scl && !sda_oe))
        else $error("bus not released after reset");

    // only start and stop may move sda under a high scl
    sda_stable_scl_high: assert property (@(posedge CLK) disable iff (RESET)
        (scl && $past(scl) && (sda_oe != $past(sda_oe)))
            |-> (cmd == CMD_START || cmd == CMD_STOP))
        else $error("sda moved while scl high");

endmodule

bind eeprom_master_top eeprom_properties u_props (
    .CLK    (CLK),
    .RESET  (RESET),
    .busy   (busy),
    .done   (done),
    .scl    (scl),
    .sda_oe (sda_oe),
    .cmd    (cmd)
);

`default_nettype wire

// File: tb/tb_eeprom.sv
`timescale 1ns/100ps
`default_nettype none

module tb_eeprom;
    import eeprom_pkg::*;

    localparam int TIMEOUT = 3000;                  // CLK cycles per transfer

    logic              CLK;
    logic              RESET;
    logic              wr;
    logic              rd;
    logic [ADDR_W-1:0] addr;
    logic [7:0]        wdata;
    logic              busy;
    logic              done;
    logic              nack_err;
    logic [7:0]        rd_data;
    logic              scl;
    logic              sda_oe;
    logic              model_pull;
    wire               sda;
    logic [31:0]       lfsr;

    assign sda = !sda_oe && !model_pull;            // open drain with pull-up

    eeprom_master_top #(
        .CLK_DIV (4)
    ) dut (
        .CLK      (CLK),
        .RESET    (RESET),
        .wr       (wr),
        .rd       (rd),
        .addr     (addr),
        .wdata    (wdata),
        .busy     (busy),
        .done     (done),
        .nack_err (nack_err),
        .rd_data  (rd_data),
        .scl      (scl),
        .sda_oe   (sda_oe),
        .sda_in   (sda)
    );

    eeprom_model u_model (
        .scl  (scl),
        .sda  (sda),
        .pull (model_pull)
    );

    initial CLK = 1'b0;
    always #50 CLK = ~CLK;

    function automatic logic [31:0] lfsr_next(input logic [31:0] s);
        return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};
    endfunction

    task automatic check_value(input string what, input logic [31:0] actual,
                               input logic [31:0] expected);
        if (actual !== expected)
        begin
            $display("ERROR at %0t ns: %s is %h, expected %h", $time, what, actual, expected);
            $display(">>> FAIL");
            $fatal(1, "value mismatch");
        end
    endtask

    task automatic idle_gap();
        logic [2:0] n;
        n = 3'd0;
        repeat (3)
        begin
            lfsr = lfsr_next(lfsr);
            n    = {n[1:0], lfsr[0]};
        end
        repeat (n) @(posedge CLK);
    endtask

    task automatic run_op(input logic [7:0] op, input logic [ADDR_W-1:0] a,
                          input logic [7:0] d, input logic [7:0] exp_rd,
                          input logic exp_nack);
        int   cnt;
        logic finished;
        cnt      = 0;
        finished = 1'b0;
        idle_gap();
        @(posedge CLK);
        addr  <= a;
        wdata <= d;
        if (op == "W")
        begin
            wr <= 1'b1;
        end
        else
        begin
            rd <= 1'b1;
        end
        @(posedge CLK);
        wr <= 1'b0;
        rd <= 1'b0;
        while (!finished)
        begin
            @(negedge CLK);
            if (done)
            begin
                finished = 1'b1;
            end
            else
            begin
                check_value("busy during transfer", busy, 1);
                cnt = cnt + 1;
                if (cnt > TIMEOUT)
                begin
                    $display("ERROR at %0t ns: the transfer never finished", $time);
                    $display(">>> FAIL");
                    $fatal(1, "timeout");
                end
                if (op == "W" && cnt == 5)
                begin
                    @(posedge CLK);                 // request while busy, must be dropped
                    wdata <= ~d;
                    wr    <= 1'b1;
                    @(posedge CLK);
                    wr    <= 1'b0;
                end
            end
        end
        check_value("nack_err", nack_err, exp_nack);
        if (op == "R" && !exp_nack)
        begin
            check_value("rd_data", rd_data, exp_rd);
        end
        check_value("scl at done", scl, 1);
        check_value("sda_oe at done", sda_oe, 0);
        check_value("sda line at done", sda, 1);
    endtask

    initial
    begin
        int          fd;
        int          n;
        string       line;
        logic [7:0]  op;
        logic [31:0] a;
        logic [31:0] d;
        logic [31:0] exp_rd;
        logic [31:0] exp_nack;
        lfsr  = 32'h9180;
        RESET <= 1'b1;
        wr    <= 1'b0;
        rd    <= 1'b0;
        addr  <= '0;
        wdata <= 8'h00;
        repeat (3) @(posedge CLK);
        RESET <= 1'b0;
        @(negedge CLK);
        check_value("busy after reset", busy, 0);
        check_value("done after reset", done, 0);
        check_value("nack_err after reset", nack_err, 0);
        check_value("rd_data after reset", rd_data, 0);
        check_value("scl after reset", scl, 1);
        check_value("sda_oe after reset", sda_oe, 0);

        fd = $fopen("tb/eeprom_trace.txt", "r");
        if (fd == 0)
        begin
            $display("could not open the trace file tb/eeprom_trace.txt");
            $display(">>> FAIL");
            $fatal(1, "no trace");
        end
        while (!$feof(fd))
        begin
            line = "";
            n = $fgets(line, fd);
            if (line.len() > 1 && line.getc(0) != "#")
            begin
                n = $sscanf(line, "%c %h %h %h %h", op, a, d, exp_rd, exp_nack);
                if (n != 5 || (op != "W" && op != "R"))
                begin
                    $display("malformed trace line: %s", line);
                    $display(">>> FAIL");
                    $fatal(1, "bad trace");
                end
                run_op(op, a[ADDR_W-1:0], d[7:0], exp_rd[7:0], exp_nack[0]);
            end
        end
        $fclose(fd);
        $display(">>> PASS");
        $finish;
    end

endmodule

`default_nettype wire

// File: all.f
src/eeprom_pkg.sv
src/twi_pkg.sv
src/byte_shifter.sv
src/request_latch.sv
src/twi_bit_engine.sv
src/eeprom_ctrl.sv
src/eeprom_master_top.sv
tb/eeprom_model.sv
tb/eeprom_properties.sv
tb/tb_eeprom.sv

// File: run.sh
#!/bin/sh
# build and run the EEPROM master testbench with Verilator

cd "$(dirname "$0")" &&
verilator --binary --timing --assert -Wno-fatal \
    --top-module tb_eeprom -f all.f -o tb_eeprom_sim &&
./obj_dir/tb_eeprom_sim | tee /dev/stderr | grep -qx ">>> PASS" &&
echo "simulation passed" ||
{
    echo "simulation failed"
    exit 1
}

// File: tb/eeprom_trace.txt
# op addr wdata exp_rd_data exp_nack_err, values in hex
# rd_data is checked only on reads that expect no error
W 005 3c 00 0
R 005 00 3c 0
W 105 a1 00 0
W 205 b2 00 0
W 3ff 4d 00 0
W 6f0 e7 00 0
R 105 00 a1 0
R 205 00 b2 0
R 005 00 3c 0
R 3ff 00 4d 0
R 6f0 00 e7 0
W 705 99 00 1
R 7aa 00 00 1
W 012 5a 00 0
R 012 00 5a 0
R 7ff 00 00 1
R 6f0 00 e7 0
R 105 00 a1 0
